// File: calc_keypad.f
+incdir+src
src/calc_pkg.sv
src/key_event_if.sv
src/keypad_scanner.sv
src/calc_core.sv
src/result_display.sv
src/calc_keypad.sv
sim/clock_gen.sv
sim/tb_calc_keypad.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f calc_keypad.f \
    --top-module tb_calc_keypad -o sim_calc_keypad &&
./obj_dir/sim_calc_keypad ||
{ echo "calc_keypad simulation failed"; exit 1; }

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic nRST
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge clk);  // two edges in reset
        @(negedge clk);
        nRST = 1'b1;                // release away from the active edge
    end

endmodule

// File: sim/tb_calc_keypad.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module tb_calc_keypad;

    typedef logic signed [`CALC_WORD_BITS-1:0] word_t;

    localparam int PRESS_TIMEOUT = 200;     // cycles from press to disp_valid
    localparam int RESET_TIMEOUT = 20;
    localparam int KEY_EQ  = 12;            // keypad positions as row * 4 + column
    localparam int KEY_CLR = 14;
    localparam int KEY_NEG = 15;
    localparam int OPC_NONE = 0;            // model operator codes
    localparam int OPC_ADD  = 1;
    localparam int OPC_SUB  = 2;
    localparam int OPC_MUL  = 3;

    logic                            clk;
    logic                            nRST;
    logic [3:0]                      row_in;
    logic [3:0]                      col_out;
    logic [4*`CALC_BCD_DIGITS-1:0]   disp_digits;
    logic                            disp_neg;
    logic                            disp_valid;

    int          pressed_idx = -1;          // key held on the pad or -1 for none
    logic [15:0] lfsr_state = 16'd20;       // seed

    word_t m_entry = '0;                    // reference calculator state
    word_t m_acc = '0;
    word_t m_show = '0;
    int    m_cnt = 0;
    bit    m_set = 1'b0;
    int    m_op = OPC_NONE;

    clock_gen u_clk (
        .clk  (clk),
        .nRST (nRST)
    );

    calc_keypad uut (
        .clk         (clk),
        .nRST        (nRST),
        .row_in      (row_in),
        .col_out     (col_out),
        .disp_digits (disp_digits),
        .disp_neg    (disp_neg),
        .disp_valid  (disp_valid)
    );

    // row pulled low only while its column is selected
    initial begin
        row_in = 4'hF;
        forever begin
            @(negedge clk);
            row_in = 4'hF;
            if (pressed_idx >= 0 && !col_out[pressed_idx[1:0]])
                row_in[pressed_idx[3:2]] = 1'b0;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);     // one step per bit
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int rand_below(input int n);
        return take_bits(8) % n;
    endfunction

    // digit to keypad position
    function automatic int digit_key(input int d);
        case (d)
            0: return 13;
            1: return 0;
            2: return 1;
            3: return 2;
            4: return 4;
            5: return 5;
            6: return 6;
            7: return 8;
            8: return 9;
            default: return 10;
        endcase
    endfunction

    function automatic int op_key(input int k);   // 0 add, 1 sub, 2 mul
        case (k)
            0: return 3;
            1: return 7;
            default: return 11;
        endcase
    endfunction

    // pending op on acc and entry with 16-bit wrap
    function automatic word_t model_combine();
        word_t res;
        case (m_op)
            OPC_ADD: res = m_acc + m_entry;
            OPC_SUB: res = m_acc - m_entry;
            OPC_MUL: res = m_acc * m_entry;
            default: res = m_set ? m_entry : m_acc;  // untouched entry keeps acc
        endcase
        return res;
    endfunction

    function automatic void model_digit(input int d);
        if (m_cnt < `CALC_MAX_DIGITS) begin
            m_entry = m_entry * word_t'(10) + word_t'(d);
            m_cnt++;
            m_set = 1'b1;
        end
        m_show = m_entry;                   // full entry ignores the digit
    endfunction

    function automatic void model_finish(input int next_op);
        m_acc   = model_combine();
        m_op    = next_op;
        m_entry = '0;
        m_cnt   = 0;
        m_set   = 1'b0;
        m_show  = m_acc;
    endfunction

    function automatic void model_key(input int idx);
        case (idx)
            0:  model_digit(1);
            1:  model_digit(2);
            2:  model_digit(3);
            3:  model_finish(OPC_ADD);
            4:  model_digit(4);
            5:  model_digit(5);
            6:  model_digit(6);
            7:  model_finish(OPC_SUB);
            8:  model_digit(7);
            9:  model_digit(8);
            10: model_digit(9);
            11: model_finish(OPC_MUL);
            12: model_finish(OPC_NONE);     // equals
            13: model_digit(0);
            14: begin
                m_entry = '0;
                m_acc   = '0;
                m_cnt   = 0;
                m_set   = 1'b0;
                m_op    = OPC_NONE;
                m_show  = '0;
            end
            default: begin
                m_entry = -m_entry;         // negate
                m_set   = 1'b1;
                m_show  = m_entry;
            end
        endcase
    endfunction

    // magnitude split into decimal digits with ones first
    function automatic int bcd_of(input word_t v);
        int mag;
        int res;
        mag = v[`CALC_WORD_BITS-1] ? -int'(v) : int'(v);
        res = 0;
        for (int d = 0; d < `CALC_BCD_DIGITS; d++) begin
            res = res | ((mag % 10) << (4 * d));
            mag = mag / 10;
        end
        return res;
    endfunction

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (disp_valid) begin
                $display("display updated while no full key press was made");
                stop_run();
            end
        end
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (nRST !== 1'b1) begin
            if (waited >= RESET_TIMEOUT) begin
                $display("reset was never released");
                stop_run();
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic check_scan(input int n);
        logic [3:0] seen;
        seen = 4'h0;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (disp_valid) begin
                $display("disp_valid pulsed with no key pressed after reset");
                stop_run();
            end
            check_value("scan one low column", 1, $countones(~col_out));
            seen = seen | ~col_out;         // columns visited so far
        end
        check_value("scan all columns", 15, int'(seen));
    endtask

    // hold a key until the display answers, then release and settle
    task automatic press_key(input int idx, input string test);
        int waited;
        int exp_digits;
        int exp_neg;
        model_key(idx);
        exp_digits = bcd_of(m_show);
        exp_neg = int'(m_show[`CALC_WORD_BITS-1]);
        @(posedge clk);
        pressed_idx = idx;
        waited = 0;
        @(negedge clk);
        while (!disp_valid) begin
            if (waited >= PRESS_TIMEOUT) begin
                $display("no display update after pressing key %0d in %s", idx, test);
                stop_run();
            end
            waited++;
            @(negedge clk);
        end
        check_value({test, " sign"}, exp_neg, int'(disp_neg));
        check_value({test, " digits"}, exp_digits, int'(disp_digits));
        @(posedge clk);
        pressed_idx = -1;
        idle_cycles(`CALC_DEBOUNCE_CYCLES + 4);     // release debounce and rescan
    endtask

    // short press with fewer low cycles than the debounce needs
    task automatic glitch_key(input int idx, input int len);
        @(posedge clk);
        pressed_idx = idx;
        idle_cycles(len);
        @(posedge clk);
        pressed_idx = -1;
    endtask

    task automatic enter_operand(input string test);
        int n;
        n = 1 + rand_below(4);
        for (int i = 0; i < n; i++)
            press_key(digit_key(take_bits(4) % 10), test);
    endtask

    initial begin
        int n_digits;
        int n_operands;
        wait_reset();
        check_scan(40);

        // digit entry past the length limit
        for (int t = 0; t < 6; t++) begin
            press_key(KEY_CLR, "digit entry clear");
            n_digits = 1 + rand_below(6);
            for (int i = 0; i < n_digits; i++)
                press_key(digit_key(take_bits(4) % 10), "digit entry");
        end

        // left to right chains
        for (int t = 0; t < 10; t++) begin
            press_key(KEY_CLR, "arithmetic clear");
            n_operands = 2 + rand_below(3);
            for (int o = 0; o < n_operands; o++) begin
                enter_operand("arithmetic operand");
                if (o == n_operands - 1)
                    press_key(KEY_EQ, "arithmetic equals");
                else
                    press_key(op_key(rand_below(3)), "arithmetic operator");
            end
        end

        // negate feeds the next op and the result carries past equals
        for (int t = 0; t < 4; t++) begin
            press_key(KEY_CLR, "negate clear");
            enter_operand("negate operand");
            press_key(KEY_NEG, "negate entry");
            press_key(op_key(rand_below(3)), "negate operator");
            enter_operand("negate operand");
            if (take_bits(1) == 1)
                press_key(KEY_NEG, "negate second entry");
            press_key(KEY_EQ, "negate equals");
            press_key(op_key(rand_below(3)), "carry operator");
            enter_operand("carry operand");
            press_key(KEY_EQ, "carry equals");
            press_key(KEY_CLR, "clear after result");
            enter_operand("fresh operand");
            press_key(op_key(rand_below(3)), "fresh operator");
            enter_operand("fresh operand");
            press_key(KEY_EQ, "fresh equals");
        end

        // bounces must not reach the display
        for (int t = 0; t < 5; t++) begin
            glitch_key(take_bits(4), 1 + rand_below(`CALC_DEBOUNCE_CYCLES - 1));
            idle_cycles(`CALC_DEBOUNCE_CYCLES + 4);
        end
        idle_cycles(200);
        press_key(take_bits(4), "debounce full press");

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: src/calc_config.svh
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// cycles a key must stay low to count as pressed
// the same count of all-high cycles ends a release
`define CALC_DEBOUNCE_CYCLES 10

// operand length limit in decimal digits
`define CALC_MAX_DIGITS 4

// accumulator and display word width
`define CALC_WORD_BITS 16

// bcd digits on the display, enough for 32768
`define CALC_BCD_DIGITS 5

`endif

// File: src/calc_core.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module calc_core (
    input  logic                 clk,
    input  logic                 nRST,
    key_event_if.sink            key,
    output logic                 show_valid,    // one cycle after key_taken
    output calc_pkg::calc_word_t show_value
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(`CALC_MAX_DIGITS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`CALC_MAX_DIGITS);
    localparam calc_word_t TEN = calc_word_t'(10);

    calc_word_t       entry;        // operand being typed
    calc_word_t       acc;          // running result
    calc_word_t       appended;     // entry with the new digit
    calc_word_t       combined;     // acc after the pending op
    logic [CNT_W-1:0] dig_cnt;      // digits in the entry
    logic             entry_set;    // entry touched since last op or equals
    op_t              pend_op;
    logic             take_now;     // payload consumed this cycle

    // left to right, all results wrap at word width
    function automatic calc_word_t apply_op(
        input op_t        op,
        input calc_word_t lhs,
        input calc_word_t rhs
    );
        calc_word_t res;
        case (op)
            OP_ADD:  res = lhs + rhs;
            OP_SUB:  res = lhs - rhs;
            OP_MUL:  res = lhs * rhs;   // low half of the product
            default: res = rhs;         // first operand of a chain
        endcase
        return res;
    endfunction

    always_comb begin
        appended = entry * TEN
                 + calc_word_t'({{(`CALC_WORD_BITS-4){1'b0}}, key.key_digit});
        // after equals with nothing typed the result carries on
        if (pend_op == OP_NONE && !entry_set)
            combined = acc;
        else
            combined = apply_op(pend_op, acc, entry);
    end

    assign take_now = key.key_ready && key.key_taken;   // data still held this cycle

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key.key_taken <= 1'b0;
            show_valid    <= 1'b0;
            show_value    <= '0;
            entry         <= '0;
            acc           <= '0;
            dig_cnt       <= '0;
            entry_set     <= 1'b0;
            pend_op       <= OP_NONE;
        end else begin
            key.key_taken <= key.key_ready && !key.key_taken;  // single pulse per key
            show_valid    <= take_now;
            if (take_now) begin
                case (key.key_kind)
                    KEY_DIGIT: begin
                        if (dig_cnt < CNT_MAX) begin
                            entry      <= appended;
                            dig_cnt    <= dig_cnt + 1'b1;
                            entry_set  <= 1'b1;
                            show_value <= appended;
                        end else begin
                            show_value <= entry;    // entry full, digit dropped
                        end
                    end
                    KEY_OP: begin
                        acc        <= combined;
                        pend_op    <= key.key_op;
                        entry      <= '0;
                        dig_cnt    <= '0;
                        entry_set  <= 1'b0;
                        show_value <= combined;
                    end
                    KEY_EQUALS: begin
                        acc        <= combined;     // stays as next first operand
                        pend_op    <= OP_NONE;
                        entry      <= '0;
                        dig_cnt    <= '0;
                        entry_set  <= 1'b0;
                        show_value <= combined;
                    end
                    KEY_NEGATE: begin
                        entry      <= -entry;
                        entry_set  <= 1'b1;
                        show_value <= -entry;
                    end
                    KEY_CLEAR: begin
                        entry      <= '0;
                        acc        <= '0;
                        dig_cnt    <= '0;
                        entry_set  <= 1'b0;
                        pend_op    <= OP_NONE;
                        show_value <= '0;
                    end
                    default: show_value <= entry;
                endcase
            end
        end
    end

endmodule

// File: src/calc_keypad.sv
`timescale 1ns/1ps

module calc_keypad (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [3:0]            row_in,       // keypad rows, active low
    output logic [3:0]            col_out,      // keypad columns, one low
    output calc_pkg::bcd_digits_t disp_digits,
    output logic                  disp_neg,
    output logic                  disp_valid    // one pulse per accepted key
);
    import calc_pkg::*;

    key_event_if key_if ();     // scanner to core handshake

    logic       show_valid;
    calc_word_t show_value;

    // column scan, debounce and key decode
    keypad_scanner u_scanner (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .key     (key_if.source)
    );

    // entry, accumulator and arithmetic
    calc_core u_core (
        .clk        (clk),
        .nRST       (nRST),
        .key        (key_if.sink),
        .show_valid (show_valid),
        .show_value (show_value)
    );

    // signed word to sign plus bcd
    result_display u_display (
        .clk         (clk),
        .nRST        (nRST),
        .show_valid  (show_valid),
        .show_value  (show_value),
        .disp_digits (disp_digits),
        .disp_neg    (disp_neg),
        .disp_valid  (disp_valid)
    );

endmodule

// File: src/calc_pkg.sv
`include "calc_config.svh"

package calc_pkg;

    // what a decoded key asks the core to do
    typedef enum logic [2:0] {
        KEY_DIGIT  = 3'd0,  // 0..9 on key_digit
        KEY_OP     = 3'd1,  // operator on key_op
        KEY_EQUALS = 3'd2,
        KEY_CLEAR  = 3'd3,
        KEY_NEGATE = 3'd4   // flips sign of the entry
    } key_kind_t;

    // pending arithmetic operator
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,     // nothing pending, entry loads acc
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2,
        OP_MUL  = 2'd3
    } op_t;

    // two's complement data word, wraps on overflow
    typedef logic signed [`CALC_WORD_BITS-1:0] calc_word_t;

    // display digits, [0] is the ones digit
    typedef logic [`CALC_BCD_DIGITS-1:0][3:0] bcd_digits_t;

endpackage

// File: src/key_event_if.sv
`timescale 1ns/1ps

interface key_event_if;
    import calc_pkg::*;

    logic       key_ready;  // level, held until taken
    key_kind_t  key_kind;   // stable while key_ready
    logic [3:0] key_digit;  // valid for KEY_DIGIT
    op_t        key_op;     // valid for KEY_OP
    logic       key_taken;  // one cycle ack from the core

    // scanner side
    modport source (
        output key_ready, key_kind, key_digit, key_op,
        input  key_taken
    );

    // core side
    modport sink (
        input  key_ready, key_kind, key_digit, key_op,
        output key_taken
    );

endinterface

// File: src/keypad_scanner.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module keypad_scanner (
    input  logic        clk,
    input  logic        nRST,
    input  logic [3:0]  row_in,     // active low, pulled up
    output logic [3:0]  col_out,    // one bit low at a time
    key_event_if.source key
);
    import calc_pkg::*;

    localparam int DEB_W = $clog2(`CALC_DEBOUNCE_CYCLES + 1);
    localparam logic [DEB_W-1:0] DEB_LAST = DEB_W'(`CALC_DEBOUNCE_CYCLES - 1);

    typedef enum logic [2:0] {
        S_IDLE,         // one cycle after reset or release
        S_SCAN,         // walking the low column
        S_DEBOUNCE,     // column frozen, key must stay low
        S_HOLD,         // key_ready up, waiting for the core
        S_RELEASE       // waiting for all rows high
    } state_t;

    state_t           state;
    state_t           state_nxt;
    logic [1:0]       col_idx;      // column currently driven low
    logic [DEB_W-1:0] deb_cnt;      // press or release cycles so far
    logic             any_low;      // some row pulled low
    logic [1:0]       low_row;      // lowest row that is low
    logic [3:0]       key_idx;      // row * 4 + column
    key_kind_t        dec_kind;
    logic [3:0]       dec_digit;
    op_t              dec_op;

    // row detect, lowest row wins on multiple presses
    always_comb begin
        any_low = ~&row_in;
        low_row = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_in[r]) low_row = 2'(r);   // later pass = lower row
        end
    end

    assign key_idx = {low_row, col_idx};

    // position to key, fixed keypad legend
    always_comb begin
        dec_kind  = KEY_DIGIT;
        dec_digit = 4'd0;
        dec_op    = OP_NONE;
        case (key_idx)
            4'd0:  dec_digit = 4'd1;
            4'd1:  dec_digit = 4'd2;
            4'd2:  dec_digit = 4'd3;
            4'd3:  begin dec_kind = KEY_OP; dec_op = OP_ADD; end
            4'd4:  dec_digit = 4'd4;
            4'd5:  dec_digit = 4'd5;
            4'd6:  dec_digit = 4'd6;
            4'd7:  begin dec_kind = KEY_OP; dec_op = OP_SUB; end
            4'd8:  dec_digit = 4'd7;
            4'd9:  dec_digit = 4'd8;
            4'd10: dec_digit = 4'd9;
            4'd11: begin dec_kind = KEY_OP; dec_op = OP_MUL; end
            4'd12: dec_kind = KEY_EQUALS;
            4'd13: dec_digit = 4'd0;
            4'd14: dec_kind = KEY_CLEAR;
            default: dec_kind = KEY_NEGATE;     // index 15
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:     state_nxt = S_SCAN;
            S_SCAN:     if (any_low) state_nxt = S_DEBOUNCE;
            S_DEBOUNCE: begin
                if (!any_low) state_nxt = S_SCAN;               // glitch, back to scan
                else if (deb_cnt == DEB_LAST) state_nxt = S_HOLD;
            end
            S_HOLD:     if (key.key_taken) state_nxt = S_RELEASE;
            S_RELEASE:  if (!any_low && deb_cnt == DEB_LAST) state_nxt = S_IDLE;
            default:    state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= S_IDLE;
            col_idx <= 2'd0;
            deb_cnt <= '0;
        end else begin
            state <= state_nxt;
            // column only moves while nothing is pressed
            if (state == S_IDLE || (state == S_SCAN && !any_low))
                col_idx <= col_idx + 2'd1;  // wraps 3 -> 0
            case (state)
                S_SCAN:     deb_cnt <= DEB_W'(1);        // press cycle counts as first
                S_DEBOUNCE: deb_cnt <= deb_cnt + 1'b1;
                S_RELEASE:  deb_cnt <= any_low ? '0 : deb_cnt + 1'b1;   // bounce restarts
                default:    deb_cnt <= '0;
            endcase
        end
    end

    // key payload, captured as debounce completes
    always_ff @(posedge clk) begin
        if (state == S_DEBOUNCE && state_nxt == S_HOLD) begin
            key.key_kind  <= dec_kind;
            key.key_digit <= dec_digit;
            key.key_op    <= dec_op;
        end
    end

    assign key.key_ready = (state == S_HOLD);

    always_comb begin
        col_out          = 4'b1111;
        col_out[col_idx] = 1'b0;
    end

endmodule

// File: src/result_display.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module result_display (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  show_valid,   // starts or restarts a conversion
    input  calc_pkg::calc_word_t  show_value,
    output calc_pkg::bcd_digits_t disp_digits,
    output logic                  disp_neg,
    output logic                  disp_valid
);
    import calc_pkg::*;

    localparam int BITS   = `CALC_WORD_BITS;
    localparam int BCD_W  = 4 * `CALC_BCD_DIGITS;
    localparam int STEP_W = $clog2(BITS);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(BITS - 1);

    logic [BITS:0]       mag;       // one extra bit so -32768 fits
    logic                busy;
    logic [STEP_W-1:0]   step;      // shift steps done
    logic                sign_q;
    logic [BCD_W-1:0]    bcd_q;
    logic [BCD_W-1:0]    bcd_adj;   // after add-3 on each digit
    logic [BCD_W-1:0]    bcd_nxt;
    logic [BITS-1:0]     bin_q;     // magnitude bits still to shift in
    logic [BITS-1:0]     bin_nxt;

    // sign-extend then negate if negative
    assign mag = show_value[BITS-1] ? -{show_value[BITS-1], show_value}
                                    : {1'b0, show_value};

    // one double dabble step
    always_comb begin
        bcd_adj = bcd_q;
        for (int d = 0; d < `CALC_BCD_DIGITS; d++) begin
            if (bcd_q[4*d +: 4] >= 4'd5)
                bcd_adj[4*d +: 4] = bcd_q[4*d +: 4] + 4'd3;
        end
        bcd_nxt = {bcd_adj[BCD_W-2:0], bin_q[BITS-1]};
        bin_nxt = {bin_q[BITS-2:0], 1'b0};
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy        <= 1'b0;
            step        <= '0;
            disp_digits <= '0;
            disp_neg    <= 1'b0;
            disp_valid  <= 1'b0;
        end else begin
            disp_valid <= 1'b0;
            if (show_valid) begin
                busy <= 1'b1;   // load wins over a running conversion
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == STEP_LAST) begin
                    busy        <= 1'b0;
                    disp_digits <= bcd_nxt;     // last step result straight out
                    disp_neg    <= sign_q;
                    disp_valid  <= 1'b1;
                end
            end
        end
    end

    // conversion datapath
    always_ff @(posedge clk) begin
        if (show_valid) begin
            sign_q <= show_value[BITS-1];
            // load does the first shift, bcd is zero so no add-3
            bcd_q  <= {{(BCD_W-1){1'b0}}, mag[BITS]};
            bin_q  <= mag[BITS-1:0];
        end else if (busy) begin
            bcd_q <= bcd_nxt;
            bin_q <= bin_nxt;
        end
    end

endmodule
